// ==== Makefile ====
# Verilator build for the chipset register bridge

VERILATOR ?= verilator
TOP       ?= chipRegBridgeTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/chipBusPkg.sv ====
/* Chipset register bridge
   Shared bus types */
package chipBusPkg;

    //////////////////////////////
    // Address window
    //////////////////////////////

    localparam logic [11:0] REG_BASE_HI = 12'hDFF;  // Custom chip registers live at DFFxxx
    localparam logic [1:0]  SIZ_BYTE    = 2'b01;    // 68000 size code for one byte

    //////////////////////////////
    // Bus bundles
    //////////////////////////////

    // CPU side request, held until regTa
    typedef struct packed {
        logic        valid;  // Request pending
        logic        rnw;    // High for read
        logic [1:0]  siz;    // 01 byte, 10 word, 00 long
        logic [23:0] addr;
    } cpuReq_t;

    // Byte lanes in use, high active
    typedef struct packed {
        logic upper;  // D15..D8, even byte
        logic lower;  // D7..D0, odd byte
    } laneSel_t;

    // Colour clock phase strobes, one CLK40 wide
    typedef struct packed {
        logic s2Edge;  // C3 falls with C1 low
        logic s4Edge;  // C3 rises with C1 high
        logic s7Edge;  // C1 rises with C3 low
    } ccPhase_t;

    // Chip side register bus
    typedef struct packed {
        logic       nAs;     // Address strobe
        logic       nUds;    // Upper data strobe
        logic       nLds;    // Lower data strobe
        logic       rnw;
        logic [7:0] regNum;  // Word register number
    } chipBus_t;

    // MC68000 states 2, 4, 6 and 7
    typedef enum logic [1:0] {
        stIdle   = 2'd0,
        stWaitS4 = 2'd1,
        stWaitS6 = 2'd2,
        stEnd    = 2'd3
    } regState_t;

endpackage

// ==== hw/chipRegBridge.sv ====
/* Chipset register bridge top */
`timescale 1ns/1ps

module chipRegBridge (
    input  logic                 CLK40,
    input  logic                 nRESET,
    input  logic                 C1,
    input  logic                 C3,
    input  logic                 nDbr,
    input  logic                 casAgnus,
    input  chipBusPkg::cpuReq_t  req,
    output chipBusPkg::chipBus_t bus,
    output logic                 nRegEn,
    output logic                 regTa,
    output logic                 regCycle
);
    import chipBusPkg::*;

    ccPhase_t   phase;   // Colour clock strobes
    logic       regHit;
    laneSel_t   lanes;
    logic [7:0] regNum;

    // C1 and C3 into CLK40 domain
    colorClockSync uSync (
        .CLK40  (CLK40),
        .nRESET (nRESET),
        .C1     (C1),
        .C3     (C3),
        .phase  (phase)
    );

    // Address window and lanes
    regSpaceDecode uDecode (
        .req    (req),
        .regHit (regHit),
        .lanes  (lanes),
        .regNum (regNum)
    );

    chipRegCycle uCycle (
        .CLK40    (CLK40),
        .nRESET   (nRESET),
        .phase    (phase),
        .regHit   (regHit),
        .rnw      (req.rnw),
        .lanes    (lanes),
        .regNum   (regNum),
        .nDbr     (nDbr),
        .casAgnus (casAgnus),
        .bus      (bus),
        .nRegEn   (nRegEn),
        .regTa    (regTa),
        .regCycle (regCycle)
    );

endmodule

// ==== hw/chipRegCycle.sv ====
/* MC68000 style register cycle */
`timescale 1ns/1ps

module chipRegCycle (
    input  logic                 CLK40,
    input  logic                 nRESET,
    input  chipBusPkg::ccPhase_t phase,
    input  logic                 regHit,
    input  logic                 rnw,
    input  chipBusPkg::laneSel_t lanes,
    input  logic [7:0]           regNum,
    input  logic                 nDbr,
    input  logic                 casAgnus,
    output chipBusPkg::chipBus_t bus,
    output logic                 nRegEn,
    output logic                 regTa,
    output logic                 regCycle
);
    import chipBusPkg::*;

    regState_t  state;
    logic       asEn;       // Address strobe active
    logic       dsEn;       // Data strobes allowed
    logic       regEnQ;
    logic       taQ;        // Acknowledge strobe
    logic       cycleQ;
    laneSel_t   laneLat;    // Lanes captured at state 2
    logic       rnwLat;
    logic [7:0] regNumLat;
    logic       startCycle;
    logic       dmaFree;

    assign startCycle = phase.s2Edge && regHit;  // Cycles only open at state 2
    assign dmaFree    = nDbr && !casAgnus;       // Agnus owns the bus otherwise

    //////////////////////////////
    // Cycle FSM
    //////////////////////////////

    always_ff @(negedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            state  <= stIdle;
            asEn   <= 1'b0;
            dsEn   <= 1'b0;
            regEnQ <= 1'b0;
            taQ    <= 1'b0;
            cycleQ <= 1'b0;
        end else begin
            taQ <= 1'b0;  // One clock wide unless set below
            case (state)
                stIdle: begin
                    if (startCycle) begin
                        asEn   <= 1'b1;
                        regEnQ <= 1'b1;
                        cycleQ <= 1'b1;
                        dsEn   <= rnw;  // Reads strobe early
                        state  <= stWaitS4;
                    end else begin
                        cycleQ <= 1'b0;  // Drops one clock after the cycle ends
                    end
                end
                stWaitS4: begin
                    if (phase.s4Edge) begin
                        dsEn <= 1'b1;  // Write data strobes
                        if (dmaFree) begin
                            state <= stWaitS6;
                        end
                        // else wait for the next S4
                    end
                end
                stWaitS6: begin
                    if (phase.s2Edge) begin
                        taQ   <= rnwLat;  // Read data valid here
                        state <= stEnd;
                    end
                end
                stEnd: begin
                    if (phase.s7Edge) begin
                        asEn   <= 1'b0;
                        dsEn   <= 1'b0;
                        regEnQ <= 1'b0;
                        taQ    <= !rnwLat;  // Write done as strobes release
                        state  <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // Request payload, held for the whole cycle
    always_ff @(negedge CLK40) begin
        if ((state == stIdle) && startCycle) begin
            laneLat   <= lanes;
            rnwLat    <= rnw;
            regNumLat <= regNum;
        end
    end

    //////////////////////////////
    // Outputs
    //////////////////////////////

    always_comb begin
        bus.nAs    = !asEn;
        bus.nUds   = !(laneLat.upper && dsEn);
        bus.nLds   = !(laneLat.lower && dsEn);
        bus.rnw    = rnwLat;
        bus.regNum = regNumLat;
    end

    assign nRegEn   = !regEnQ;
    assign regTa    = taQ;
    assign regCycle = cycleQ;

    // Acknowledge is a strobe, never a level
    assert property (@(negedge CLK40) disable iff (!nRESET) regTa |=> !regTa)
        else $error("regTa high for two clocks");

    // Data strobes only inside an address strobe
    assert property (@(negedge CLK40) disable iff (!nRESET)
        (!bus.nUds || !bus.nLds) |-> !bus.nAs)
        else $error("data strobe active with nAs high");

endmodule

// ==== hw/colorClockSync.sv ====
/* Colour clock synchroniser */
`timescale 1ns/1ps

module colorClockSync (
    input  logic                 CLK40,
    input  logic                 nRESET,
    input  logic                 C1,
    input  logic                 C3,
    output chipBusPkg::ccPhase_t phase
);

    logic [1:0] c1Hist;  // [1] older sample, [0] newer sample
    logic [1:0] c3Hist;

    //////////////////////////////
    // Two stage history
    //////////////////////////////

    always_ff @(posedge CLK40 or negedge nRESET) begin
        if (!nRESET) begin
            c1Hist <= 2'b11;  // Both clocks read as high out of reset
            c3Hist <= 2'b11;
        end else begin
            c1Hist <= {c1Hist[0], C1};
            c3Hist <= {c3Hist[0], C3};
        end
    end

    //////////////////////////////
    // Phase edge decode
    //////////////////////////////

    always_comb begin
        phase.s2Edge = (c1Hist == 2'b00) && (c3Hist == 2'b10);  // C3 falling, C1 low
        phase.s4Edge = (c1Hist == 2'b11) && (c3Hist == 2'b01);  // C3 rising, C1 high
        phase.s7Edge = (c1Hist == 2'b01) && (c3Hist == 2'b00);  // C1 rising, C3 low
    end

    // C1 and C3 run in quadrature, so only one of them switches per sample
    assert property (@(posedge CLK40) disable iff (!nRESET)
        !((c1Hist[1] != c1Hist[0]) && (c3Hist[1] != c3Hist[0])))
        else $error("C1 and C3 changed in the same clock");

endmodule

// ==== hw/regSpaceDecode.sv ====
/* Register window decode */
`timescale 1ns/1ps

module regSpaceDecode (
    input  chipBusPkg::cpuReq_t  req,
    output logic                 regHit,
    output chipBusPkg::laneSel_t lanes,
    output logic [7:0]           regNum
);
    import chipBusPkg::*;

    logic inWindow;
    logic evenByte;

    //////////////////////////////
    // Window compare
    //////////////////////////////

    assign inWindow = (req.addr[23:12] == REG_BASE_HI);
    assign regHit   = req.valid && inWindow;  // Level, follows the held request

    //////////////////////////////
    // Byte lanes
    //////////////////////////////

    // Byte access to an even address uses the upper lane only
    assign evenByte = (req.siz == SIZ_BYTE) && !req.addr[0];

    always_comb begin
        lanes.upper = !req.addr[0];  // Even address drives D15..D8
        lanes.lower = !evenByte;     // Words, longs and odd bytes
    end

    //////////////////////////////
    // Register number
    //////////////////////////////

    // Word register index inside the window
    assign regNum = req.addr[8:1];

endmodule

// ==== sim/chipRegTests.svh ====
/* Directed register cycle tests */
`ifndef CHIP_REG_TESTS_SVH
`define CHIP_REG_TESTS_SVH

// Xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

//////////////////////////////
// One request to its acknowledge
//////////////////////////////

task automatic runRegCycle(input logic rnwIn, input logic [1:0] sizIn,
                           input logic [23:0] addrIn, input int holdCycles,
                           input logic holdCas);
    cpuReq_t r;
    logic    expUpper;
    logic    expLower;
    logic    dsSeen;
    logic    dropNow;
    int      cyc;
    int      taCount;
    int      asLow;    // Samples with nAs low so far
    int      tail;     // Samples after the cycle closed
    expUpper = !addrIn[0];                           // Even address uses D15..D8
    expLower = !((sizIn == 2'b01) && !addrIn[0]);    // All but even bytes use D7..D0
    r        = '{valid: 1'b1, rnw: rnwIn, siz: sizIn, addr: addrIn};
    dsSeen   = 1'b0;
    dropNow  = 1'b0;
    cyc      = 0;
    taCount  = 0;
    asLow    = 0;
    tail     = 0;
    @(negedge CLK40);
    req <= r;
    if (holdCycles > 0) begin
        if (holdCas) casAgnus <= 1'b1;
        else nDbr <= 1'b0;
    end
    while (cyc < holdCycles + 5 * COLOR_PERIOD && tail < 8) begin
        @(posedge CLK40);  // Outputs settle on the falling edge
        if (!bus.nAs) begin
            asLow++;
            if (asLow == 1) begin
                if (bus.regNum !== addrIn[8:1])
                    showMismatch("bus.regNum", 32'(bus.regNum), 32'(addrIn[8:1]));
                if (bus.rnw !== rnwIn) showMismatch("bus.rnw", 32'(bus.rnw), 32'(rnwIn));
                if (nRegEn !== 1'b0) showMismatch("nRegEn", 32'(nRegEn), 32'h0);
                if (regCycle !== 1'b1) showMismatch("regCycle", 32'(regCycle), 32'h1);
            end
        end
        if (!dsSeen && (!bus.nUds || !bus.nLds)) begin
            dsSeen = 1'b1;
            if (bus.nUds !== !expUpper) showMismatch("bus.nUds", 32'(bus.nUds), 32'(!expUpper));
            if (bus.nLds !== !expLower) showMismatch("bus.nLds", 32'(bus.nLds), 32'(!expLower));
            if (rnwIn && asLow != 1) countFailure("read data strobes not with nAs");
            if (!rnwIn && asLow <= 7) countFailure("write data strobes within first phase");
        end
        if (regTa) begin
            taCount++;
            dropNow = 1'b1;
            if (!nDbr || casAgnus) countFailure("regTa while DMA holds the bus");
            if (rnwIn && bus.nAs) countFailure("read regTa after nAs released");
            if (!rnwIn && !bus.nAs) countFailure("write regTa before nAs released");
        end
        if (taCount > 0 && bus.nAs) tail++;
        @(negedge CLK40);
        cyc++;
        if (dropNow) begin
            req.valid <= 1'b0;  // CPU lets go one clock after regTa
            dropNow = 1'b0;
        end
        if (cyc == holdCycles) begin
            nDbr     <= 1'b1;
            casAgnus <= 1'b0;
        end
    end
    if (taCount == 0) countFailure($sformatf("no regTa for request to 0x%06h", addrIn));
    else if (taCount != 1) showMismatch("regTa count", 32'(taCount), 32'h1);
    if (!dsSeen) countFailure("data strobes never went active");
    req.valid <= 1'b0;
    nDbr      <= 1'b1;
    casAgnus  <= 1'b0;
endtask

// Bus must stay idle for two colour periods
task automatic watchIdle(input string what);
    logic bad;
    int   n;
    bad = 1'b0;
    for (n = 0; n < 2 * COLOR_PERIOD; n++) begin
        @(posedge CLK40);
        if (!bad && {bus.nAs, bus.nUds, bus.nLds, nRegEn, regTa, regCycle} !== 6'b111100) begin
            bad = 1'b1;
            showMismatch(what, 32'({bus.nAs, bus.nUds, bus.nLds, nRegEn, regTa, regCycle}),
                         32'h3C);
        end
    end
    @(negedge CLK40);
endtask

//////////////////////////////
// Directed tests
//////////////////////////////

task automatic testIdleAfterReset();
    watchIdle("idle {nAs,nUds,nLds,nRegEn,regTa,regCycle}");
endtask

task automatic testWordRead();
    runRegCycle(1'b1, 2'b10, {REG_BASE_HI, 12'h01C}, 0, 1'b0);
endtask

task automatic testByteWrites();
    runRegCycle(1'b0, 2'b01, {REG_BASE_HI, 12'h09A}, 0, 1'b0);  // Even byte, upper lane
    runRegCycle(1'b0, 2'b01, {REG_BASE_HI, 12'h09B}, 0, 1'b0);  // Odd byte, lower lane
endtask

task automatic testDmaHold();
    runRegCycle(1'b1, 2'b10, {REG_BASE_HI, 12'h006}, 3 * COLOR_PERIOD, 1'b0);  // nDbr low
    runRegCycle(1'b0, 2'b10, {REG_BASE_HI, 12'h180}, 3 * COLOR_PERIOD, 1'b1);  // casAgnus
endtask

task automatic testOutsideWindow();
    @(negedge CLK40);
    req <= '{valid: 1'b1, rnw: 1'b1, siz: 2'b10, addr: 24'hDFE09A};  // Just below window
    watchIdle("outside window {nAs,nUds,nLds,nRegEn,regTa,regCycle}");
    req.valid <= 1'b0;
endtask

task automatic testRandomRequests();
    logic [1:0]  siz;
    logic [23:0] addr;
    int          n;
    for (n = 0; n < 20; n++) begin
        rngState = xorshift32(rngState);
        case (rngState[17:16])
            2'd1:    siz = 2'b10;
            2'd2:    siz = 2'b00;
            default: siz = 2'b01;
        endcase
        addr = {REG_BASE_HI, rngState[11:0]};
        if (siz != 2'b01) addr[0] = 1'b0;  // Words and longs are aligned
        runRegCycle(rngState[12], siz, addr, 0, 1'b0);
    end
endtask

`endif

// ==== sim/chipRegBridgeTb.sv ====
/* Register bridge testbench */
`timescale 1ns/1ps

module chipRegBridgeTb;
    import chipBusPkg::*;

    localparam int COLOR_PERIOD = 28;  // CLK40 cycles per colour clock, 7 per quarter
    localparam int BUS_CYCLES   = 27;  // 25 register cycles plus two idle windows
    localparam int WATCHDOG_NS  = BUS_CYCLES * 16 * COLOR_PERIOD * 10;

    logic        CLK40;
    logic        nRESET;
    logic        C1;
    logic        C3;
    logic        nDbr;
    logic        casAgnus;
    cpuReq_t     req;
    chipBus_t    bus;
    logic        nRegEn;
    logic        regTa;
    logic        regCycle;
    int          mismatchCount = 0;
    int          failCount     = 0;
    logic [31:0] rngState      = 32'h54f5abdd;  // Xorshift state

    chipRegBridge dut (.*);

    task automatic showMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        mismatchCount++;
        $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic countFailure(input string what);
        failCount++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    `include "chipRegTests.svh"

    //////////////////////////////
    // Clocks
    //////////////////////////////

    initial begin
        CLK40 = 1'b0;
        forever #5 CLK40 = ~CLK40;  // 10 ns period
    end

    // Quadrature pair, C3 a quarter behind C1
    initial begin
        int phaseCnt;
        phaseCnt = 0;
        C1 = 1'b0;
        C3 = 1'b0;
        forever begin
            @(negedge CLK40);
            C1 <= (phaseCnt < 14);
            C3 <= (phaseCnt >= 7) && (phaseCnt < 21);
            phaseCnt = (phaseCnt + 1) % COLOR_PERIOD;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        req      = '0;
        nDbr     = 1'b1;  // No DMA request
        casAgnus = 1'b0;
        nRESET   = 1'b0;
        repeat (5) @(posedge CLK40);
        @(negedge CLK40);
        nRESET <= 1'b1;
        testIdleAfterReset();
        testWordRead();
        testByteWrites();
        testDmaHold();
        testOutsideWindow();
        testRandomRequests();
        $display("Summary: %0d mismatches, %0d other errors", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Hang guard, 16 colour periods per bus cycle
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired with the cycle FSM in %s", dut.uCycle.state.name());
        $display("Summary: %0d mismatches, %0d other errors", mismatchCount, failCount);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+sim
hw/chipBusPkg.sv
hw/colorClockSync.sv
hw/regSpaceDecode.sv
hw/chipRegCycle.sv
hw/chipRegBridge.sv
sim/chipRegBridgeTb.sv
